// File: logic/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

    ////////////////////////////////////////////////////////////
    // payload carried by every fetched instruction
    ////////////////////////////////////////////////////////////

    // instruction address
    typedef logic [31:0] pc_t;

    // raw instruction word as fetched
    typedef logic [31:0] inst_t;

    // branch type bits on top of the predicted target
    typedef logic [33:0] brinfo_t;

    // exception raised during fetch, zero when clean
    typedef logic [7:0] ecode_t;

endpackage : core_types_pkg

`default_nettype wire

// File: logic/iq_pkg.sv
`default_nettype none

package iq_pkg;

    // two banks, one per issue slot
    localparam int NUM_BANKS = 2;

    // bank holding the next instruction in program order
    typedef enum logic {
        BANK_A = 1'b0,
        BANK_B = 1'b1
    } bank_sel_e;

endpackage : iq_pkg

`default_nettype wire

// File: logic/iq_bank.sv
`timescale 1ns/1ps
`default_nettype none

module iq_bank
    import core_types_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  wire logic clk,
    input  wire logic rstn,
    input  wire logic i_flush,

    input  wire logic    i_wr_en,
    input  pc_t          i_wr_pc,
    input  inst_t        i_wr_inst,
    input  brinfo_t      i_wr_brinfo,
    input  ecode_t       i_wr_ecode,

    input  wire logic    i_rd_en,
    output pc_t          o_rd_pc,
    output inst_t        o_rd_inst,
    output brinfo_t      o_rd_brinfo,
    output ecode_t       o_rd_ecode,

    output logic         o_empty,
    output logic         o_nearly_full
);

    localparam int CNT_W = $clog2(DEPTH) + 1;

    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [DEPTH-1:0] onehot_t;

    // record storage, no reset
    pc_t     mem_pc     [DEPTH];
    inst_t   mem_inst   [DEPTH];
    brinfo_t mem_brinfo [DEPTH];
    ecode_t  mem_ecode  [DEPTH];

    onehot_t wr_ptr;
    onehot_t rd_ptr;
    cnt_t    count;
    cnt_t    count_nxt;

    logic    do_wr;
    logic    do_rd;

    // full bank drops the write
    assign do_wr = i_wr_en && !i_flush && (count != cnt_t'(DEPTH));
    assign do_rd = i_rd_en && !i_flush && !o_empty;

    assign o_empty = (count == '0);

    always_comb begin
        count_nxt = count;
        if (do_wr && !do_rd) begin
            count_nxt = count + cnt_t'(1);
        end else if (do_rd && !do_wr) begin
            count_nxt = count - cnt_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            wr_ptr        <= onehot_t'(1);
            rd_ptr        <= onehot_t'(1);
            count         <= '0;
            o_nearly_full <= 1'b0;
        end else begin
            // rotate left by one entry
            if (do_wr) begin
                wr_ptr <= {wr_ptr[DEPTH-2:0], wr_ptr[DEPTH-1]};
            end
            if (do_rd) begin
                rd_ptr <= {rd_ptr[DEPTH-2:0], rd_ptr[DEPTH-1]};
            end
            count         <= count_nxt;
            // two slots of headroom for a pair already in flight
            o_nearly_full <= (count_nxt >= cnt_t'(DEPTH - 2));
        end
    end

    ////////////////////////////////////////////////////////////
    // storage write and head select
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (do_wr && wr_ptr[i]) begin
                mem_pc[i]     <= i_wr_pc;
                mem_inst[i]   <= i_wr_inst;
                mem_brinfo[i] <= i_wr_brinfo;
                mem_ecode[i]  <= i_wr_ecode;
            end
        end
    end

    // one-hot mux over the read pointer
    always_comb begin
        o_rd_pc     = '0;
        o_rd_inst   = '0;
        o_rd_brinfo = '0;
        o_rd_ecode  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (rd_ptr[i]) begin
                o_rd_pc     = o_rd_pc | mem_pc[i];
                o_rd_inst   = o_rd_inst | mem_inst[i];
                o_rd_brinfo = o_rd_brinfo | mem_brinfo[i];
                o_rd_ecode  = o_rd_ecode | mem_ecode[i];
            end
        end
    end

endmodule : iq_bank

`default_nettype wire

// File: logic/iq_steer.sv
`timescale 1ns/1ps
`default_nettype none

module iq_steer
    import core_types_pkg::*;
    import iq_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire logic       i_flush,

    input  wire logic [1:0] i_valid,
    input  pc_t             i_pc1,
    input  inst_t           i_inst1,
    input  brinfo_t         i_brinfo1,
    input  ecode_t          i_ecode1,
    input  pc_t             i_pc2,
    input  inst_t           i_inst2,
    input  brinfo_t         i_brinfo2,
    input  ecode_t          i_ecode2,

    input  wire logic [NUM_BANKS-1:0] i_nearly_full,

    output logic [NUM_BANKS-1:0] o_bank_wr,
    output pc_t                  o_bank_pc     [NUM_BANKS],
    output inst_t                o_bank_inst   [NUM_BANKS],
    output brinfo_t              o_bank_brinfo [NUM_BANKS],
    output ecode_t               o_bank_ecode  [NUM_BANKS],
    output logic                 o_full
);

    // banks rely on one-hot rotation and a DEPTH-2 threshold
    if (DEPTH < 4 || (DEPTH & (DEPTH - 1)) != 0) begin : g_bad_depth
        $error("iq_steer: DEPTH must be a power of two of at least 4");
    end

    bank_sel_e in_ptr;

    logic pair_in;
    logic single_in;

    assign pair_in   = i_valid[0] && i_valid[1];
    assign single_in = i_valid[0] && !i_valid[1];

    ////////////////////////////////////////////////////////////
    // slot to bank routing
    ////////////////////////////////////////////////////////////

    // pointed bank takes slot 1, the other takes slot 2
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (in_ptr == bank_sel_e'(b[0])) begin
                o_bank_wr[b]     = i_valid[0] && !i_flush;
                o_bank_pc[b]     = i_pc1;
                o_bank_inst[b]   = i_inst1;
                o_bank_brinfo[b] = i_brinfo1;
                o_bank_ecode[b]  = i_ecode1;
            end else begin
                o_bank_wr[b]     = pair_in && !i_flush;
                o_bank_pc[b]     = i_pc2;
                o_bank_inst[b]   = i_inst2;
                o_bank_brinfo[b] = i_brinfo2;
                o_bank_ecode[b]  = i_ecode2;
            end
        end
    end

    // a pair leaves the pointer where it was
    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            in_ptr <= BANK_A;
        end else if (single_in) begin
            in_ptr <= (in_ptr == BANK_A) ? BANK_B : BANK_A;
        end
    end

    assign o_full = |i_nearly_full;

endmodule : iq_steer

`default_nettype wire

// File: logic/iq_merge.sv
`timescale 1ns/1ps
`default_nettype none

module iq_merge
    import core_types_pkg::*;
    import iq_pkg::*;
(
    input  wire logic clk,
    input  wire logic rstn,
    input  wire logic i_flush,
    input  wire logic i_stall,

    input  wire logic [NUM_BANKS-1:0] i_empty,
    input  pc_t                       i_head_pc     [NUM_BANKS],
    input  inst_t                     i_head_inst   [NUM_BANKS],
    input  brinfo_t                   i_head_brinfo [NUM_BANKS],
    input  ecode_t                    i_head_ecode  [NUM_BANKS],

    output logic [NUM_BANKS-1:0] o_bank_rd,

    output pc_t        o_pc1,
    output inst_t      o_inst1,
    output brinfo_t    o_brinfo1,
    output ecode_t     o_ecode1,
    output pc_t        o_pc2,
    output inst_t      o_inst2,
    output brinfo_t    o_brinfo2,
    output ecode_t     o_ecode2,

    output logic [1:0] o_valid,
    output logic       o_busy
);

    bank_sel_e out_ptr;
    bank_sel_e other;

    logic pop_first;
    logic pop_second;

    assign other = (out_ptr == BANK_A) ? BANK_B : BANK_A;

    ////////////////////////////////////////////////////////////
    // pop decision
    ////////////////////////////////////////////////////////////

    // oldest lives in the pointed bank, nothing moves if it is empty
    assign pop_first  = !i_stall && !i_flush && !i_empty[out_ptr];
    assign pop_second = pop_first && !i_empty[other];

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (out_ptr == bank_sel_e'(b[0])) begin
                o_bank_rd[b] = pop_first;
            end else begin
                o_bank_rd[b] = pop_second;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // registered output pair
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_ptr   <= BANK_A;
            o_valid   <= 2'b00;
            o_pc1     <= '0;
            o_inst1   <= '0;
            o_brinfo1 <= '0;
            o_ecode1  <= '0;
            o_pc2     <= '0;
            o_inst2   <= '0;
            o_brinfo2 <= '0;
            o_ecode2  <= '0;
        end else if (i_flush) begin
            out_ptr <= BANK_A;
            o_valid <= 2'b00;
        end else if (!i_stall) begin
            o_valid <= {pop_second, pop_first};
            if (pop_first) begin
                o_pc1     <= i_head_pc[out_ptr];
                o_inst1   <= i_head_inst[out_ptr];
                o_brinfo1 <= i_head_brinfo[out_ptr];
                o_ecode1  <= i_head_ecode[out_ptr];
            end
            if (pop_second) begin
                o_pc2     <= i_head_pc[other];
                o_inst2   <= i_head_inst[other];
                o_brinfo2 <= i_head_brinfo[other];
                o_ecode2  <= i_head_ecode[other];
            end
            // single pop hands the next turn to the other bank
            if (pop_first && !pop_second) begin
                out_ptr <= other;
            end
        end
    end

    assign o_busy = |o_valid;

endmodule : iq_merge

`default_nettype wire

// File: logic/id_queue.sv
`timescale 1ns/1ps
`default_nettype none

module id_queue
    import core_types_pkg::*;
    import iq_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire logic       i_flush,
    input  wire logic       i_stall,

    input  wire logic [1:0] i_valid,
    input  pc_t             i_pc1,
    input  inst_t           i_inst1,
    input  brinfo_t         i_brinfo1,
    input  ecode_t          i_ecode1,
    input  pc_t             i_pc2,
    input  inst_t           i_inst2,
    input  brinfo_t         i_brinfo2,
    input  ecode_t          i_ecode2,

    output pc_t             o_pc1,
    output inst_t           o_inst1,
    output brinfo_t         o_brinfo1,
    output ecode_t          o_ecode1,
    output pc_t             o_pc2,
    output inst_t           o_inst2,
    output brinfo_t         o_brinfo2,
    output ecode_t          o_ecode2,

    output logic [1:0]      o_valid,
    output logic            o_full,
    output logic            o_busy
);

    // steer to banks
    logic [NUM_BANKS-1:0] bank_wr;
    pc_t                  bank_wr_pc     [NUM_BANKS];
    inst_t                bank_wr_inst   [NUM_BANKS];
    brinfo_t              bank_wr_brinfo [NUM_BANKS];
    ecode_t               bank_wr_ecode  [NUM_BANKS];

    // banks to merge
    logic [NUM_BANKS-1:0] bank_rd;
    logic [NUM_BANKS-1:0] bank_empty;
    logic [NUM_BANKS-1:0] bank_nearly_full;
    pc_t                  bank_head_pc     [NUM_BANKS];
    inst_t                bank_head_inst   [NUM_BANKS];
    brinfo_t              bank_head_brinfo [NUM_BANKS];
    ecode_t               bank_head_ecode  [NUM_BANKS];

    iq_steer #(
        .DEPTH(DEPTH)
    ) u_steer (
        .clk           (clk),
        .rstn          (rstn),
        .i_flush       (i_flush),
        .i_valid       (i_valid),
        .i_pc1         (i_pc1),
        .i_inst1       (i_inst1),
        .i_brinfo1     (i_brinfo1),
        .i_ecode1      (i_ecode1),
        .i_pc2         (i_pc2),
        .i_inst2       (i_inst2),
        .i_brinfo2     (i_brinfo2),
        .i_ecode2      (i_ecode2),
        .i_nearly_full (bank_nearly_full),
        .o_bank_wr     (bank_wr),
        .o_bank_pc     (bank_wr_pc),
        .o_bank_inst   (bank_wr_inst),
        .o_bank_brinfo (bank_wr_brinfo),
        .o_bank_ecode  (bank_wr_ecode),
        .o_full        (o_full)
    );

    ////////////////////////////////////////////////////////////
    // interleaved banks
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        iq_bank #(
            .DEPTH(DEPTH)
        ) u_bank (
            .clk           (clk),
            .rstn          (rstn),
            .i_flush       (i_flush),
            .i_wr_en       (bank_wr[g]),
            .i_wr_pc       (bank_wr_pc[g]),
            .i_wr_inst     (bank_wr_inst[g]),
            .i_wr_brinfo   (bank_wr_brinfo[g]),
            .i_wr_ecode    (bank_wr_ecode[g]),
            .i_rd_en       (bank_rd[g]),
            .o_rd_pc       (bank_head_pc[g]),
            .o_rd_inst     (bank_head_inst[g]),
            .o_rd_brinfo   (bank_head_brinfo[g]),
            .o_rd_ecode    (bank_head_ecode[g]),
            .o_empty       (bank_empty[g]),
            .o_nearly_full (bank_nearly_full[g])
        );
    end

    iq_merge u_merge (
        .clk           (clk),
        .rstn          (rstn),
        .i_flush       (i_flush),
        .i_stall       (i_stall),
        .i_empty       (bank_empty),
        .i_head_pc     (bank_head_pc),
        .i_head_inst   (bank_head_inst),
        .i_head_brinfo (bank_head_brinfo),
        .i_head_ecode  (bank_head_ecode),
        .o_bank_rd     (bank_rd),
        .o_pc1         (o_pc1),
        .o_inst1       (o_inst1),
        .o_brinfo1     (o_brinfo1),
        .o_ecode1      (o_ecode1),
        .o_pc2         (o_pc2),
        .o_inst2       (o_inst2),
        .o_brinfo2     (o_brinfo2),
        .o_ecode2      (o_ecode2),
        .o_valid       (o_valid),
        .o_busy        (o_busy)
    );

endmodule : id_queue

`default_nettype wire

// File: verif/id_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_queue_tb
    import core_types_pkg::*;
();

    localparam int DEPTH       = 16;
    localparam int WAIT_LIMIT  = 20;
    localparam int DRAIN_LIMIT = 300;

    // {pc, inst, brinfo, ecode} = [105:74] [73:42] [41:8] [7:0]
    typedef logic [105:0] rec_t;

    logic       clk;
    logic       rstn;
    logic       i_flush;
    logic       i_stall;
    logic [1:0] i_valid;
    pc_t        i_pc1;
    inst_t      i_inst1;
    brinfo_t    i_brinfo1;
    ecode_t     i_ecode1;
    pc_t        i_pc2;
    inst_t      i_inst2;
    brinfo_t    i_brinfo2;
    ecode_t     i_ecode2;
    pc_t        o_pc1;
    inst_t      o_inst1;
    brinfo_t    o_brinfo1;
    ecode_t     o_ecode1;
    pc_t        o_pc2;
    inst_t      o_inst2;
    brinfo_t    o_brinfo2;
    ecode_t     o_ecode2;
    logic [1:0] o_valid;
    logic       o_full;
    logic       o_busy;

    // expected records in program order
    rec_t        sb_q [$];
    integer      seed = 47008;
    logic [31:0] seq_num = 32'd0;
    int          check_count = 0;
    int          error_count = 0;

    // state seen by the monitor
    logic       full_seen = 1'b0;
    logic       s_rstn;
    logic       s_flush;
    logic       s_stall;
    logic [1:0] snap_valid = 2'b00;
    rec_t       snap_rec1;
    rec_t       snap_rec2;
    rec_t       out_rec1;
    rec_t       out_rec2;

    assign out_rec1 = {o_pc1, o_inst1, o_brinfo1, o_ecode1};
    assign out_rec2 = {o_pc2, o_inst2, o_brinfo2, o_ecode2};

    id_queue #(
        .DEPTH(DEPTH)
    ) dut0 (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
            error_count++;
        end
    endtask

    // unique pc per instruction with the rest scrambled from it
    task automatic make_record(output rec_t rec);
        pc_t         pc;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        pc      = 32'h0000_4000 + (seq_num << 2);
        seq_num = seq_num + 32'd1;
        r1      = $random(seed);
        r2      = $random(seed);
        r3      = $random(seed);
        rec     = {pc, pc ^ r1, {r3[1:0], pc + r2}, pc[9:2] ^ r3[9:2]};
    endtask

    // pattern 0 idles and 1 sends slot 1 only, anything higher sends a pair
    task automatic drive_cycle(input int pattern, input logic stall);
        rec_t r1;
        rec_t r2;
        @(posedge clk);
        i_stall <= stall;
        if (pattern == 0 || full_seen) begin
            i_valid <= 2'b00;
        end else begin
            make_record(r1);
            sb_q.push_back(r1);
            {i_pc1, i_inst1, i_brinfo1, i_ecode1} <= r1;
            if (pattern >= 2) begin
                make_record(r2);
                sb_q.push_back(r2);
                {i_pc2, i_inst2, i_brinfo2, i_ecode2} <= r2;
                i_valid <= 2'b11;
            end else begin
                i_valid <= 2'b01;
            end
        end
    endtask

    task automatic take_output(input rec_t actual, input string slot);
        rec_t exp;
        if (sb_q.size() == 0) begin
            $display("Unexpected output in %s at %0t ns with nothing outstanding", slot, $time);
            error_count++;
        end else begin
            exp = sb_q.pop_front();
            check_value(128'(actual[105:74]), 128'(exp[105:74]), {slot, " pc"});
            check_value(128'(actual[73:42]), 128'(exp[73:42]), {slot, " inst"});
            check_value(128'(actual[41:8]), 128'(exp[41:8]), {slot, " brinfo"});
            check_value(128'(actual[7:0]), 128'(exp[7:0]), {slot, " ecode"});
        end
    endtask

    task automatic wait_drain(input string what);
        int   n;
        logic busy;
        n    = 0;
        busy = 1'b1;
        while (busy && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
            busy = (sb_q.size() != 0) || (snap_valid != 2'b00);
        end
        if (busy) begin
            $display("Timeout: %s stream did not drain, %0d left", what, sb_q.size());
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-12s done, %0d errors", name, error_count - errs_before);
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////

    // what the DUT saw at the last edge
    always @(posedge clk) begin
        s_rstn  <= rstn;
        s_flush <= i_flush;
        s_stall <= i_stall;
    end

    always @(negedge clk) begin
        if (s_rstn && !s_flush) begin
            if (s_stall) begin
                check_value(128'(o_valid), 128'(snap_valid), "o_valid held under stall");
                check_value(128'(out_rec1), 128'(snap_rec1), "slot 1 held under stall");
                check_value(128'(out_rec2), 128'(snap_rec2), "slot 2 held under stall");
            end else begin
                if (o_valid[0]) begin
                    take_output(out_rec1, "slot 1");
                end
                if (o_valid[1]) begin
                    take_output(out_rec2, "slot 2");
                end
            end
            check_value(128'(o_busy), 128'(|o_valid), "o_busy");
        end
        snap_valid = o_valid;
        snap_rec1  = out_rec1;
        snap_rec2  = out_rec2;
        full_seen  = o_full;
    end

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        int errs;
        errs = error_count;
        @(negedge clk);
        check_value(128'(o_valid), '0, "o_valid after reset");
        check_value(128'(o_full), '0, "o_full after reset");
        check_value(128'(o_busy), '0, "o_busy after reset");
        check_value(128'(out_rec1), '0, "slot 1 fields after reset");
        check_value(128'(out_rec2), '0, "slot 2 fields after reset");
        report_test("reset", errs);
    endtask

    task automatic test_single();
        int   errs;
        int   edges;
        logic got;
        rec_t sent;
        errs  = error_count;
        edges = 0;
        got   = 1'b0;
        drive_cycle(1, 1'b0);
        sent = sb_q[sb_q.size() - 1];
        // first edge counted is the one that samples the input
        while (!got && edges < WAIT_LIMIT) begin
            @(posedge clk);
            i_valid <= 2'b00;
            edges++;
            @(negedge clk);
            got = (o_valid != 2'b00);
        end
        if (!got) begin
            $display("Timeout: single instruction never reached the outputs");
            error_count++;
        end else begin
            check_value(128'(edges), 128'(2), "edges from sample to o_valid");
            check_value(128'(o_valid), 128'(2'b01), "o_valid for one instruction");
            check_value(128'(o_busy), 128'(1'b1), "o_busy with output valid");
            check_value(128'(out_rec1), 128'(sent), "slot 1 record");
        end
        wait_drain("single");
        report_test("single", errs);
    endtask

    task automatic test_mixed();
        int errs;
        int k;
        int pat [12];
        errs = error_count;
        pat  = '{2, 1, 1, 0, 2, 2, 1, 0, 1, 2, 1, 1};
        for (k = 0; k < 12; k++) begin
            drive_cycle(pat[k], 1'b0);
        end
        drive_cycle(0, 1'b0);
        wait_drain("mixed");
        report_test("mixed order", errs);
    endtask

    task automatic test_stall_fill();
        int errs;
        int k;
        errs = error_count;
        for (k = 0; k < 40 && !full_seen; k++) begin
            drive_cycle(2, 1'b1);
        end
        check_value(128'(full_seen), 128'(1'b1), "o_full under stall");
        check_value(128'(sb_q.size() >= 2 * (DEPTH - 2)), 128'(1'b1),
                    "entries accepted before o_full");
        // fetch keeps offering pairs that o_full holds back
        for (k = 0; k < 3; k++) begin
            drive_cycle(2, 1'b1);
        end
        drive_cycle(0, 1'b0);
        wait_drain("stall");
        report_test("stall fill", errs);
    endtask

    task automatic test_flush();
        int errs;
        int k;
        errs = error_count;
        drive_cycle(2, 1'b0);
        drive_cycle(2, 1'b0);
        // fill under stall until fetch sees o_full
        for (k = 0; k < 40 && !full_seen; k++) begin
            drive_cycle(2, 1'b1);
        end
        @(negedge clk);
        check_value(128'(o_valid != 2'b00), 128'(1'b1), "outputs valid before flush");
        check_value(128'(o_full), 128'(1'b1), "o_full before flush");
        // flush wins over the stall still raised
        @(posedge clk);
        i_valid <= 2'b00;
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
        i_stall <= 1'b0;
        sb_q.delete();
        @(negedge clk);
        check_value(128'(o_valid), '0, "o_valid after flush");
        check_value(128'(o_full), '0, "o_full after flush");
        for (k = 0; k < 6; k++) begin
            drive_cycle(k % 3, 1'b0);
        end
        drive_cycle(0, 1'b0);
        wait_drain("post-flush");
        report_test("flush", errs);
    endtask

    task automatic test_random();
        int          errs;
        int          k;
        logic [31:0] r;
        errs = error_count;
        for (k = 0; k < 300; k++) begin
            r = $random(seed);
            drive_cycle(int'(r[1:0]), r[4:2] == 3'd0);
        end
        drive_cycle(0, 1'b0);
        wait_drain("random");
        check_value(128'(sb_q.size()), '0, "scoreboard empty at end");
        report_test("random", errs);
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        i_flush   = 1'b0;
        i_stall   = 1'b0;
        i_valid   = 2'b00;
        i_pc1     = '0;
        i_inst1   = '0;
        i_brinfo1 = '0;
        i_ecode1  = '0;
        i_pc2     = '0;
        i_inst2   = '0;
        i_brinfo2 = '0;
        i_ecode2  = '0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        test_reset();
        test_single();
        test_mixed();
        test_stall_fill();
        test_flush();
        test_random();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : id_queue_tb

`default_nettype wire

// File: vlog.f
logic/core_types_pkg.sv
logic/iq_pkg.sv
logic/iq_bank.sv
logic/iq_steer.sv
logic/iq_merge.sv
logic/id_queue.sv
verif/id_queue_tb.sv

// File: Makefile
# Verilator build and run of the instruction buffer testbench

VERILATOR ?= verilator
TOP       ?= id_queue_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
